/* logic/dcache_pkg.sv */
// Data cache shared definitions

package dcache_pkg;

	// ========================================
	// Geometry
	// ========================================

	// Byte address width seen by the load/store unit
	localparam int ADDR_W   = 32;
	// One cache line carries eight bytes
	localparam int LINE_W   = 64;
	localparam int OFFSET_W = 3;
	// Each bank is four-way set associative
	localparam int WAYS     = 4;
	localparam int SETS     = 32;
	localparam int SET_W    = 5;
	// Bits 8:3 give the line number inside a 64-line window and bit 3 picks the bank
	localparam int TAG_LSB  = 9;

	// ========================================
	// Vector types
	// ========================================

	typedef logic [ADDR_W-1:0]         addr_t;
	typedef logic [LINE_W-1:0]         line_t;
	// Tag is everything above the window, bits 31:9
	typedef logic [ADDR_W-TAG_LSB-1:0] tag_t;
	typedef logic [SET_W-1:0]          set_t;
	typedef logic [1:0]                way_t;
	// One bit per way, used for valid bits, hit masks and fill selects
	typedef logic [WAYS-1:0]           way_mask_t;
	// Statistics counters saturate at all ones
	typedef logic [15:0]               count_t;

	// ========================================
	// Register map
	// ========================================

	// Addresses of the control and statistics registers
	typedef enum logic [1:0] {
		REG_ENABLE = 2'd0,
		REG_HITS   = 2'd1,
		REG_MISSES = 2'd2
	} reg_sel_e;

endpackage

/* logic/dcache_way_ram.sv */
// Cache way storage
`timescale 1ns/10ps

module dcache_way_ram (
	input  logic              clk,
	input  logic              wr_i,
	input  dcache_pkg::set_t  wr_set_i,
	input  dcache_pkg::tag_t  wr_tag_i,
	input  dcache_pkg::line_t wr_data_i,
	input  dcache_pkg::set_t  rd_set_i,
	input  dcache_pkg::set_t  snoop_set_i,
	output dcache_pkg::tag_t  rd_tag_o,
	output dcache_pkg::line_t rd_data_o,
	output dcache_pkg::tag_t  snoop_tag_o
);
	import dcache_pkg::*;

	// Line data and the tag used by lookups
	line_t data_mem [SETS];
	tag_t  tag_mem [SETS];
	// Second tag copy so a snoop never steals a read port from a lookup
	tag_t  snoop_mem [SETS];

	// ========================================
	// Write port
	// ========================================

	// A fill writes data and both tag copies at the same set
	always_ff @(posedge clk) begin
		if (wr_i) begin
			data_mem[wr_set_i]  <= wr_data_i;
			tag_mem[wr_set_i]   <= wr_tag_i;
			snoop_mem[wr_set_i] <= wr_tag_i;
		end
	end

	// ========================================
	// Read ports
	// ========================================

	// Lookup side read, registered so it maps onto block RAM
	// A read in the cycle of a write returns the old contents
	always_ff @(posedge clk) begin
		rd_tag_o  <= tag_mem[rd_set_i];
		rd_data_o <= data_mem[rd_set_i];
	end

	// Snoop side read on its own index
	always_ff @(posedge clk) begin
		snoop_tag_o <= snoop_mem[snoop_set_i];
	end

endmodule

/* logic/dcache_victim.sv */
// Fill way selection
`timescale 1ns/10ps

module dcache_victim #(
	// Start value of the LFSR, must not be zero
	parameter logic [15:0] SEED = 16'h0001
) (
	input  logic                  clk,
	input  logic                  rst,
	input  dcache_pkg::way_mask_t valid_i,
	output dcache_pkg::way_mask_t way_o
);
	import dcache_pkg::*;

	logic [15:0] lfsr_q;
	logic        feedback;
	way_t        rand_way;

	// ========================================
	// Random source
	// ========================================

	// Taps 16, 15, 13 and 4 give the full 65535 state sequence
	assign feedback = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];

	// Steps every cycle whether or not a fill is happening
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr_q <= SEED;
		end else begin
			lfsr_q <= {lfsr_q[14:0], feedback};
		end
	end

	// Two low bits are enough to name one of four ways
	assign rand_way = lfsr_q[1:0];

	// ========================================
	// Victim choice
	// ========================================

	// Free ways are used first, lowest number first
	// Only a full set falls back on the random way
	always_comb begin
		way_o = '0;
		if (&valid_i) begin
			way_o = way_mask_t'(1) << rand_way;
		end else begin
			// Scan downwards so the lowest free way is the last one kept
			for (int w = WAYS - 1; w >= 0; w--) begin
				if (!valid_i[w]) begin
					way_o = way_mask_t'(1) << w;
				end
			end
		end
	end

endmodule

/* logic/dcache_bank.sv */
// Single cache bank
`timescale 1ns/10ps

module dcache_bank #(
	// 0 for the even line bank, 1 for the odd line bank
	parameter int ODD_BANK = 0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              enable_i,
	input  logic              lookup_i,
	input  dcache_pkg::set_t  lookup_set_i,
	input  dcache_pkg::tag_t  lookup_tag_i,
	input  logic              fill_i,
	input  dcache_pkg::set_t  fill_set_i,
	input  dcache_pkg::tag_t  fill_tag_i,
	input  dcache_pkg::line_t fill_data_i,
	input  logic              inv_line_i,
	input  dcache_pkg::set_t  inv_set_i,
	input  logic              inv_all_i,
	input  logic              snoop_v_i,
	input  dcache_pkg::set_t  snoop_set_i,
	input  dcache_pkg::tag_t  snoop_tag_i,
	output logic              hit_o,
	output dcache_pkg::line_t line_o
);
	import dcache_pkg::*;

	// Valid bits as flops so a whole set or the whole bank clears in one edge
	way_mask_t valid_r [SETS];

	// Per way RAM outputs
	tag_t      way_tag [WAYS];
	line_t     way_data [WAYS];
	tag_t      way_snoop_tag [WAYS];

	// Fill side
	logic      fill_en;
	way_mask_t fill_way;

	// Lookup pipeline, stage 1 lines up with the registered RAM reads
	logic      lookup_q;
	tag_t      lookup_tag_q;
	way_mask_t valid_s1;
	way_mask_t hit_mask;
	way_t      hit_way;
	logic      hit_any;

	// Snoop pipeline
	logic      snoop_v_q;
	set_t      snoop_set_q;
	tag_t      snoop_tag_q;
	way_mask_t snoop_hit;

	// ========================================
	// Way storage and victim choice
	// ========================================

	// A disabled cache takes no new lines
	assign fill_en = fill_i & enable_i;

	// Seeds differ so the two banks do not evict in lockstep
	dcache_victim #(
		.SEED(ODD_BANK != 0 ? 16'hace1 : 16'h0001)
	) u_victim (
		.clk     (clk),
		.rst     (rst),
		.valid_i (valid_r[fill_set_i]),
		.way_o   (fill_way)
	);

	for (genvar g = 0; g < WAYS; g++) begin : g_way
		dcache_way_ram u_way_ram (
			.clk         (clk),
			.wr_i        (fill_en & fill_way[g]),
			.wr_set_i    (fill_set_i),
			.wr_tag_i    (fill_tag_i),
			.wr_data_i   (fill_data_i),
			.rd_set_i    (lookup_set_i),
			.snoop_set_i (snoop_set_i),
			.rd_tag_o    (way_tag[g]),
			.rd_data_o   (way_data[g]),
			.snoop_tag_o (way_snoop_tag[g])
		);
	end

	// ========================================
	// Lookup
	// ========================================

	// Valid bits are sampled at the same edge as the RAM read
	// so a later fill cannot pair a new valid bit with old data
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lookup_q <= 1'b0;
			valid_s1 <= '0;
		end else begin
			lookup_q <= lookup_i;
			valid_s1 <= valid_r[lookup_set_i];
		end
	end

	always_ff @(posedge clk) begin
		lookup_tag_q <= lookup_tag_i;
	end

	// Tag compare on all four ways at once
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_mask[w] = valid_s1[w] && (way_tag[w] == lookup_tag_q);
		end
	end

	// Lowest hitting way wins, though at most one should ever hit
	always_comb begin
		hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (hit_mask[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit_any = lookup_q & enable_i & (|hit_mask);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= hit_any;
		end
	end

	// A miss drives an all zero line
	always_ff @(posedge clk) begin
		line_o <= hit_any ? way_data[hit_way] : '0;
	end

	// ========================================
	// Snoop compare
	// ========================================

	// Snoop tags come out of the RAM one cycle after the request
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			snoop_v_q <= 1'b0;
		end else begin
			snoop_v_q <= snoop_v_i;
		end
	end

	always_ff @(posedge clk) begin
		snoop_set_q <= snoop_set_i;
		snoop_tag_q <= snoop_tag_i;
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			snoop_hit[w] = snoop_v_q && (way_snoop_tag[w] == snoop_tag_q);
		end
	end

	// ========================================
	// Valid bits
	// ========================================

	// Later statements win, so invalidates override a fill in the same cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid_r[s] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					valid_r[fill_set_i][w] <= 1'b1;
				end
				if (snoop_hit[w]) begin
					valid_r[snoop_set_q][w] <= 1'b0;
				end
			end
			if (inv_line_i) begin
				valid_r[inv_set_i] <= '0;
			end
			if (inv_all_i) begin
				for (int s = 0; s < SETS; s++) begin
					valid_r[s] <= '0;
				end
			end
		end
	end

	// Victim logic must hand the RAMs exactly one way to write
	assert property (@(posedge clk) disable iff (rst) fill_en |-> $onehot(fill_way));

	// A line is never present twice, so one set never hits in two ways
	assert property (@(posedge clk) disable iff (rst) lookup_q |-> $onehot0(hit_mask));

endmodule

/* logic/dcache_ctrl_regs.sv */
// Cache control and statistics registers
`timescale 1ns/10ps

module dcache_ctrl_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cfg_wr_i,
	input  dcache_pkg::reg_sel_e cfg_adr_i,
	input  dcache_pkg::count_t   cfg_wdata_i,
	input  logic                 result_v_i,
	input  logic                 hit_i,
	output dcache_pkg::count_t   cfg_rdata_o,
	output logic                 enable_o
);
	import dcache_pkg::*;

	logic       enable_q;
	// Entry 0 counts hits, entry 1 counts misses
	count_t     cnt_q [2];
	logic [1:0] cnt_inc;
	logic [1:0] cnt_clr;

	// ========================================
	// Enable bit
	// ========================================

	// Cache starts disabled and software turns it on through bit 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enable_q <= 1'b0;
		end else if (cfg_wr_i && cfg_adr_i == REG_ENABLE) begin
			enable_q <= cfg_wdata_i[0];
		end
	end

	assign enable_o = enable_q;

	// ========================================
	// Statistics
	// ========================================

	// Every finished lookup bumps exactly one of the two counters
	assign cnt_inc[0] = result_v_i & hit_i;
	assign cnt_inc[1] = result_v_i & ~hit_i;
	// Any write to a counter clears it, the data is ignored
	assign cnt_clr[0] = cfg_wr_i && cfg_adr_i == REG_HITS;
	assign cnt_clr[1] = cfg_wr_i && cfg_adr_i == REG_MISSES;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt_q[0] <= '0;
			cnt_q[1] <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (cnt_clr[i]) begin
					cnt_q[i] <= '0;
				end else if (cnt_inc[i] && cnt_q[i] != '1) begin
					cnt_q[i] <= cnt_q[i] + count_t'(1);
				end
			end
		end
	end

	// Read mux follows the address with no register in between
	always_comb begin
		case (cfg_adr_i)
			REG_ENABLE: cfg_rdata_o = count_t'(enable_q);
			REG_HITS:   cfg_rdata_o = cnt_q[0];
			REG_MISSES: cfg_rdata_o = cnt_q[1];
			default:    cfg_rdata_o = '0;
		endcase
	end

	// Without a register write, a lookup result is either a hit or a miss, never both
	assert property (@(posedge clk) disable iff (rst)
		!cfg_wr_i |=> !($changed(cnt_q[0]) && $changed(cnt_q[1])));

endmodule

/* logic/dcache_top.sv */
// Two bank data cache
`timescale 1ns/10ps

module dcache_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 read_v_i,
	input  dcache_pkg::addr_t    read_adr_i,
	input  logic                 fill_i,
	input  dcache_pkg::addr_t    fill_adr_i,
	input  dcache_pkg::line_t    fill_data_i,
	input  logic                 inv_line_i,
	input  dcache_pkg::addr_t    inv_adr_i,
	input  logic                 inv_all_i,
	input  logic                 snoop_v_i,
	input  dcache_pkg::addr_t    snoop_adr_i,
	input  logic                 cfg_wr_i,
	input  dcache_pkg::reg_sel_e cfg_adr_i,
	input  dcache_pkg::count_t   cfg_wdata_i,
	output logic                 rd_valid_o,
	output logic                 hit_o,
	output logic                 lo_hit_o,
	output logic                 hi_hit_o,
	output dcache_pkg::line_t    line_lo_o,
	output dcache_pkg::line_t    line_hi_o,
	output dcache_pkg::count_t   cfg_rdata_o
);
	import dcache_pkg::*;

	// Line number L of the read address
	logic [TAG_LSB-OFFSET_W-1:0] rd_line;
	set_t  even_set;
	set_t  odd_set;
	tag_t  rd_tag;
	logic  enable;
	logic  even_hit;
	logic  odd_hit;
	line_t even_line;
	line_t odd_line;
	// Lookup valid and the reorder bit travel two stages with the banks
	logic  read_v_q;
	logic  swap_q1;
	logic  swap_q2;

	// ========================================
	// Lookup set computation
	// ========================================

	// Odd bank holds L or L+1 at set L/2, whichever of them is odd
	// Even bank needs the next set up when L itself is odd
	assign rd_line  = read_adr_i[TAG_LSB-1:OFFSET_W];
	assign odd_set  = rd_line[TAG_LSB-OFFSET_W-1:1];
	assign even_set = rd_line[TAG_LSB-OFFSET_W-1:1] + set_t'(rd_line[0]);
	// Same tag for both banks, a wrap past the window is not handled
	assign rd_tag   = read_adr_i[ADDR_W-1:TAG_LSB];

	// ========================================
	// Banks
	// ========================================

	// Fills, line invalidates and snoops go only to the bank named by bit 3
	// inv_all reaches both banks
	for (genvar b = 0; b < 2; b++) begin : g_bank
		logic  bank_hit;
		line_t bank_line;

		dcache_bank #(
			.ODD_BANK(b)
		) u_bank (
			.clk          (clk),
			.rst          (rst),
			.enable_i     (enable),
			.lookup_i     (read_v_i),
			.lookup_set_i (b != 0 ? odd_set : even_set),
			.lookup_tag_i (rd_tag),
			.fill_i       (fill_i && fill_adr_i[OFFSET_W] == b[0]),
			.fill_set_i   (fill_adr_i[TAG_LSB-1:OFFSET_W+1]),
			.fill_tag_i   (fill_adr_i[ADDR_W-1:TAG_LSB]),
			.fill_data_i  (fill_data_i),
			.inv_line_i   (inv_line_i && inv_adr_i[OFFSET_W] == b[0]),
			.inv_set_i    (inv_adr_i[TAG_LSB-1:OFFSET_W+1]),
			.inv_all_i    (inv_all_i),
			.snoop_v_i    (snoop_v_i && snoop_adr_i[OFFSET_W] == b[0]),
			.snoop_set_i  (snoop_adr_i[TAG_LSB-1:OFFSET_W+1]),
			.snoop_tag_i  (snoop_adr_i[ADDR_W-1:TAG_LSB]),
			.hit_o        (bank_hit),
			.line_o       (bank_line)
		);
	end

	assign even_hit  = g_bank[0].bank_hit;
	assign even_line = g_bank[0].bank_line;
	assign odd_hit   = g_bank[1].bank_hit;
	assign odd_line  = g_bank[1].bank_line;

	// Hit results from the output stage feed the statistics counters
	dcache_ctrl_regs u_ctrl_regs (
		.clk         (clk),
		.rst         (rst),
		.cfg_wr_i    (cfg_wr_i),
		.cfg_adr_i   (cfg_adr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.result_v_i  (rd_valid_o),
		.hit_i       (hit_o),
		.cfg_rdata_o (cfg_rdata_o),
		.enable_o    (enable)
	);

	// ========================================
	// Result alignment and reordering
	// ========================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			read_v_q   <= 1'b0;
			rd_valid_o <= 1'b0;
		end else begin
			read_v_q   <= read_v_i;
			rd_valid_o <= read_v_q;
		end
	end

	always_ff @(posedge clk) begin
		swap_q1 <= read_adr_i[OFFSET_W];
		swap_q2 <= swap_q1;
	end

	// With L odd the odd bank holds the lower line, so the banks swap
	assign lo_hit_o  = swap_q2 ? odd_hit : even_hit;
	assign hi_hit_o  = swap_q2 ? even_hit : odd_hit;
	assign line_lo_o = swap_q2 ? odd_line : even_line;
	assign line_hi_o = swap_q2 ? even_line : odd_line;
	// A full hit needs both lines of the pair
	assign hit_o     = even_hit & odd_hit;

endmodule

/* bench/dcache_tb.sv */
// Data cache testbench
`timescale 1ns/10ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int          CLK_PERIOD        = 20;
	localparam int          DRIVE_DELAY       = 2;
	localparam int          RESET_CYCLES      = 4;
	localparam int          CYCLES_PER_VECTOR = 10;
	localparam logic [31:0] RNG_SEED          = 32'h1d6efc73;

	// ========================================
	// DUT signals
	// ========================================

	logic     clk;
	logic     rst;
	logic     read_v_i;
	addr_t    read_adr_i;
	logic     fill_i;
	addr_t    fill_adr_i;
	line_t    fill_data_i;
	logic     inv_line_i;
	addr_t    inv_adr_i;
	logic     inv_all_i;
	logic     snoop_v_i;
	addr_t    snoop_adr_i;
	logic     cfg_wr_i;
	reg_sel_e cfg_adr_i;
	count_t   cfg_wdata_i;
	logic     rd_valid_o;
	logic     hit_o;
	logic     lo_hit_o;
	logic     hi_hit_o;
	line_t    line_lo_o;
	line_t    line_hi_o;
	count_t   cfg_rdata_o;

	// One entry per vector line, kept in file order
	logic [7:0] vec_op [$];
	addr_t      vec_adr [$];
	line_t      vec_data [$];
	line_t      vec_exp [$];
	logic       loaded = 1'b0;

	// Every fill the bench has issued, later entries replace earlier ones
	addr_t fill_key [$];
	line_t fill_val [$];

	logic [31:0] rng_state;
	int          hit_tally   = 0;
	int          miss_tally  = 0;
	int          error_count = 0;

	dcache_top dut (
		.clk         (clk),
		.rst         (rst),
		.read_v_i    (read_v_i),
		.read_adr_i  (read_adr_i),
		.fill_i      (fill_i),
		.fill_adr_i  (fill_adr_i),
		.fill_data_i (fill_data_i),
		.inv_line_i  (inv_line_i),
		.inv_adr_i   (inv_adr_i),
		.inv_all_i   (inv_all_i),
		.snoop_v_i   (snoop_v_i),
		.snoop_adr_i (snoop_adr_i),
		.cfg_wr_i    (cfg_wr_i),
		.cfg_adr_i   (cfg_adr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.rd_valid_o  (rd_valid_o),
		.hit_o       (hit_o),
		.lo_hit_o    (lo_hit_o),
		.hi_hit_o    (hi_hit_o),
		.line_lo_o   (line_lo_o),
		.line_hi_o   (line_hi_o),
		.cfg_rdata_o (cfg_rdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Results are counted mid cycle, well away from the edge that produced them
	always @(negedge clk) begin
		if (!rst && rd_valid_o) begin
			if (hit_o) begin
				hit_tally++;
			end else begin
				miss_tally++;
			end
		end
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Two steps of the generator make one line of fill data
	task automatic next_line(output line_t d);
		rng_state = xorshift(rng_state);
		d[63:32] = rng_state;
		rng_state = xorshift(rng_state);
		d[31:0] = rng_state;
	endtask

	function automatic addr_t line_base(input addr_t a);
		return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	endfunction

	// Data last written to the line holding a, zero if it was never filled
	function automatic line_t filled_data(input addr_t a);
		line_t d;
		d = '0;
		for (int i = 0; i < fill_key.size(); i++) begin
			if (fill_key[i] == line_base(a)) begin
				d = fill_val[i];
			end
		end
		return d;
	endfunction

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input line_t exp, input line_t act);
		assert (act === exp) else begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			error_count++;
			stop_run();
		end
	endtask

	// All stimulus changes land a short time after the rising edge
	task automatic wait_edge();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// ========================================
	// Operations
	// ========================================

	task automatic do_fill(input addr_t a, input line_t d);
		fill_i      = 1'b1;
		fill_adr_i  = a;
		fill_data_i = d;
		wait_edge();
		fill_i = 1'b0;
		fill_key.push_back(line_base(a));
		fill_val.push_back(d);
	endtask

	// Returns once rd_valid_o shows the result of this lookup
	task automatic do_lookup(input addr_t a);
		read_v_i   = 1'b1;
		read_adr_i = a;
		wait_edge();
		read_v_i = 1'b0;
		do begin
			wait_edge();
		end while (!rd_valid_o);
	endtask

	// Bit 0 of the mask says line L should hit and bit 1 says line L+1 should
	task automatic check_lookup(input string name, input addr_t a, input logic [1:0] mask);
		line_t lo_exp;
		line_t hi_exp;
		lo_exp = mask[0] ? filled_data(a) : '0;
		hi_exp = mask[1] ? filled_data(line_base(a) + addr_t'(8)) : '0;
		do_lookup(a);
		check_value($sformatf("%s lo_hit", name), line_t'(mask[0]), line_t'(lo_hit_o));
		check_value($sformatf("%s hi_hit", name), line_t'(mask[1]), line_t'(hi_hit_o));
		check_value($sformatf("%s hit", name), line_t'(&mask), line_t'(hit_o));
		check_value($sformatf("%s line_lo", name), lo_exp, line_lo_o);
		check_value($sformatf("%s line_hi", name), hi_exp, line_hi_o);
	endtask

	// Five tags into the set of base, then count which of them still hit
	task automatic run_eviction(input string name, input addr_t base, input line_t exp_hits);
		addr_t a;
		line_t d;
		int    hits;
		for (int i = 0; i < 5; i++) begin
			a = base + (addr_t'(i) << TAG_LSB);
			next_line(d);
			do_fill(a, d);
		end
		hits = 0;
		for (int i = 0; i < 5; i++) begin
			a = base + (addr_t'(i) << TAG_LSB);
			do_lookup(a);
			if (lo_hit_o) begin
				hits++;
				check_value($sformatf("%s way %0d data", name, i), filled_data(a), line_lo_o);
			end else begin
				check_value($sformatf("%s way %0d data", name, i), '0, line_lo_o);
			end
		end
		check_value($sformatf("%s hits", name), exp_hits, line_t'(hits));
	endtask

	task automatic write_reg(input addr_t a, input line_t d);
		cfg_wr_i    = 1'b1;
		cfg_adr_i   = reg_sel_e'(a[1:0]);
		cfg_wdata_i = d[15:0];
		wait_edge();
		cfg_wr_i = 1'b0;
		// Writing a counter register clears that counter
		if (a[1:0] == REG_HITS) begin
			hit_tally = 0;
		end
		if (a[1:0] == REG_MISSES) begin
			miss_tally = 0;
		end
	endtask

	task automatic check_reg(input string name, input addr_t a, input line_t exp);
		cfg_adr_i = reg_sel_e'(a[1:0]);
		wait_edge();
		check_value(name, exp, line_t'(cfg_rdata_o));
		if (a[1:0] == REG_HITS) begin
			check_value($sformatf("%s tally", name), line_t'(hit_tally[15:0]), line_t'(cfg_rdata_o));
		end
		if (a[1:0] == REG_MISSES) begin
			check_value($sformatf("%s tally", name), line_t'(miss_tally[15:0]), line_t'(cfg_rdata_o));
		end
	endtask

	// The clear lands on the second edge after the request
	task automatic do_snoop(input addr_t a);
		snoop_v_i   = 1'b1;
		snoop_adr_i = a;
		wait_edge();
		snoop_v_i = 1'b0;
		wait_edge();
	endtask

	task automatic load_vectors();
		int               fd;
		int               code;
		logic [7:0]       op;
		addr_t            a;
		line_t            d;
		line_t            e;
		logic [8*200-1:0] rest;
		fd = $fopen("bench/dcache_vectors.txt", "r");
		if (fd == 0) begin
			$display("ERROR: the vector file bench/dcache_vectors.txt could not be opened");
			stop_run();
		end
		code = $fscanf(fd, " %c", op);
		while (code == 1) begin
			if (op == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h", a, d, e);
				if (code != 3) begin
					$display("ERROR: vector line %0d does not hold three hex fields", vec_op.size());
					stop_run();
				end
				vec_op.push_back(op);
				vec_adr.push_back(a);
				vec_data.push_back(d);
				vec_exp.push_back(e);
			end
			code = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
	endtask

	task automatic run_vector(input int i);
		string name;
		line_t d;
		name = $sformatf("vector %0d %c", i, vec_op[i]);
		case (vec_op[i])
			"E": write_reg(vec_adr[i], vec_data[i]);
			"F": begin
				d = vec_data[i];
				// A zero data field asks for generated data
				if (d == '0) begin
					next_line(d);
				end
				do_fill(vec_adr[i], d);
			end
			"R": check_lookup(name, vec_adr[i], vec_exp[i][1:0]);
			"I": begin
				inv_line_i = 1'b1;
				inv_adr_i  = vec_adr[i];
				wait_edge();
				inv_line_i = 1'b0;
			end
			"A": begin
				inv_all_i = 1'b1;
				wait_edge();
				inv_all_i = 1'b0;
			end
			"S": do_snoop(vec_adr[i]);
			"C": check_reg(name, vec_adr[i], vec_exp[i]);
			"V": run_eviction(name, vec_adr[i], vec_exp[i]);
			default: begin
				$display("ERROR: vector %0d has the unknown operation %c", i, vec_op[i]);
				stop_run();
			end
		endcase
	endtask

	// ========================================
	// Sequence and watchdog
	// ========================================

	initial begin
		rst         = 1'b1;
		read_v_i    = 1'b0;
		read_adr_i  = '0;
		fill_i      = 1'b0;
		fill_adr_i  = '0;
		fill_data_i = '0;
		inv_line_i  = 1'b0;
		inv_adr_i   = '0;
		inv_all_i   = 1'b0;
		snoop_v_i   = 1'b0;
		snoop_adr_i = '0;
		cfg_wr_i    = 1'b0;
		cfg_adr_i   = REG_ENABLE;
		cfg_wdata_i = '0;
		rng_state   = RNG_SEED;
		load_vectors();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		for (int i = 0; i < vec_op.size(); i++) begin
			run_vector(i);
		end
		wait_edge();
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_run();
		end
	end

	// Budget grows with the number of vectors in the file
	initial begin
		wait (loaded);
		repeat (RESET_CYCLES + vec_op.size() * CYCLES_PER_VECTOR) @(posedge clk);
		$display("ERROR: watchdog expired before all vectors were run");
		stop_run();
	end

endmodule

/* bench/dcache_vectors.txt */
# op addr data exp, fields in hex; E reg write, F fill (data 0 = generated), R lookup,
# I line invalidate, A invalidate all, S snoop, C reg check, V eviction burst (exp = hits)
F 00001040 0 0
R 00001040 0 0
C 00000000 0 0
E 00000000 1 0
C 00000000 0 1
E 00000001 0 0
E 00000002 0 0
F 00001040 0 0
R 00001040 0 1
F 00001048 1122334455667788 0
R 00001040 0 3
F 00001068 0 0
F 00001070 0 0
R 00001068 0 3
R 00001060 0 2
I 00001040 0 0
R 00001040 0 2
R 00001068 0 3
S 00003068 0 0
R 00001068 0 3
S 00001068 0 0
R 00001068 0 2
C 00000001 0 4
C 00000002 0 4
E 00000001 0 0
C 00000001 0 0
A 00000000 0 0
R 00001048 0 0
R 00001070 0 0
V 00000400 0 4
C 00000002 0 b
C 00000001 0 0

/* dcache.f */
logic/dcache_pkg.sv
logic/dcache_way_ram.sv
logic/dcache_victim.sv
logic/dcache_bank.sv
logic/dcache_ctrl_regs.sv
logic/dcache_top.sv
bench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  # Shared package first, then the RTL from the leaves up
  - logic/dcache_pkg.sv
  - logic/dcache_way_ram.sv
  - logic/dcache_victim.sv
  - logic/dcache_bank.sv
  - logic/dcache_ctrl_regs.sv
  - logic/dcache_top.sv

  - target: test
    files:
      - bench/dcache_tb.sv
